// ==== hw/effect_envelope.sv ====
// effect envelope generator
// turns the frame mode into a steady, blink or breathe brightness envelope
`timescale 1ns/1ns
`default_nettype none

module effect_envelope #(
    parameter int ENV_PRESCALE = 1024
) (
    input  logic                  clk,
    input  logic                  reset_sig,
    input  rgbw_pkg::rgbw_frame_t frame,
    input  logic                  frame_valid,
    output logic [7:0]            env
);

    localparam int PW = (ENV_PRESCALE > 1) ? $clog2(ENV_PRESCALE) : 1;
    localparam logic [PW-1:0] PRESC_MAX = PW'(ENV_PRESCALE - 1);

    logic [PW-1:0] presc;
    logic          tick;
    logic [7:0]    mode_q;
    logic [7:0]    phase;
    logic          dir_down;
    logic          steady_mode;

    assign tick = (presc == PRESC_MAX);

    // unknown codes fall back to steady
    assign steady_mode = (mode_q == rgbw_pkg::MODE_STEADY) || (mode_q > rgbw_pkg::MODE_BREATHE);

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            presc    <= '0;
            mode_q   <= 8'd0;
            phase    <= 8'd0;
            dir_down <= 1'b0;
            env      <= 8'd0;
        end else if (frame_valid) begin
            // new frame restarts the effect from the beginning
            presc    <= '0;
            mode_q   <= frame.mode;
            phase    <= 8'd0;
            dir_down <= 1'b0;
        end else begin
            presc <= tick ? '0 : presc + 1'b1;
            if (tick) begin
                if (steady_mode) begin
                    env <= 8'hff;
                end else if (mode_q == rgbw_pkg::MODE_BLINK) begin
                    // on for the first half of the phase, off for the second
                    env   <= phase[7] ? 8'h00 : 8'hff;
                    phase <= phase + 8'd1;
                end else begin
                    env <= phase;
                    // triangle, turn around at both ends
                    if (!dir_down) begin
                        if (phase == 8'hff) begin
                            dir_down <= 1'b1;
                            phase    <= 8'hfe;
                        end else begin
                            phase <= phase + 8'd1;
                        end
                    end else if (phase == 8'h00) begin
                        dir_down <= 1'b0;
                        phase    <= 8'h01;
                    end else begin
                        phase <= phase - 8'd1;
                    end
                end
            end
        end
    end

    a_steady_full: assert property (@(posedge clk) disable iff (!reset_sig)
        (tick && !frame_valid && steady_mode) |=> (env == 8'hff));

endmodule

`default_nettype wire

// ==== hw/intensity_scaler.sv ====
// intensity scaler
// applies the frame intensity to the four colour channels, registered
`timescale 1ns/1ns
`default_nettype none

module intensity_scaler (
    input  logic                  clk,
    input  logic                  reset_sig,
    input  rgbw_pkg::rgbw_frame_t frame,
    output rgbw_pkg::rgbw_chan_t  scaled
);

    logic [8:0] gain;

    // lint of 255 gives unity gain
    assign gain = {1'b0, frame.lint} + 9'd1;

    // channel times gain, keep the upper byte of the product
    function automatic logic [7:0] scale8(input logic [7:0] chan, input logic [8:0] k);
        logic [16:0] prod;
        prod = chan * k;
        return prod[15:8];
    endfunction

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            scaled <= '0;
        end else begin
            scaled.red   <= scale8(frame.red, gain);
            scaled.green <= scale8(frame.green, gain);
            scaled.blue  <= scale8(frame.blue, gain);
            scaled.white <= scale8(frame.white, gain);
        end
    end

endmodule

`default_nettype wire

// ==== hw/pwm_mixer.sv ====
// pwm mixer
// mixes scaled colours with the envelope into four 8-bit pwm outputs
`timescale 1ns/1ns
`default_nettype none

module pwm_mixer (
    input  logic                 clk,
    input  logic                 reset_sig,
    input  rgbw_pkg::rgbw_chan_t scaled,
    input  logic [7:0]           env,
    output logic                 pwm_r,
    output logic                 pwm_g,
    output logic                 pwm_b,
    output logic                 pwm_w
);

    logic [7:0]           cnt;
    logic [8:0]           env_gain;
    rgbw_pkg::rgbw_chan_t duty_next;
    rgbw_pkg::rgbw_chan_t duty_q;
    logic [3:0][7:0]      duty_arr;
    logic [3:0][7:0]      duty_next_arr;
    logic [3:0]           pwm_vec;

    function automatic logic [7:0] mix8(input logic [7:0] chan, input logic [8:0] k);
        logic [16:0] prod;
        prod = chan * k;
        return prod[15:8];
    endfunction

    assign env_gain = {1'b0, env} + 9'd1;

    always_comb begin
        duty_next.red   = mix8(scaled.red, env_gain);
        duty_next.green = mix8(scaled.green, env_gain);
        duty_next.blue  = mix8(scaled.blue, env_gain);
        duty_next.white = mix8(scaled.white, env_gain);
    end

    // duties only change at the period boundary so no partial pulses appear
    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            cnt    <= 8'd0;
            duty_q <= '0;
        end else begin
            cnt <= cnt + 8'd1;
            if (cnt == 8'hff) begin
                duty_q <= duty_next;
            end
        end
    end

    // channel view, index 3 is red down to 0 for white
    assign duty_arr      = duty_q;
    assign duty_next_arr = duty_next;
    assign {pwm_r, pwm_g, pwm_b, pwm_w} = pwm_vec;

    for (genvar i = 0; i < 4; i++) begin : g_chan
        assign pwm_vec[i] = (cnt < duty_arr[i]);

        a_zero_duty_low: assert property (@(posedge clk) disable iff (!reset_sig)
            (cnt == 8'hff && duty_next_arr[i] == 8'd0) |=> !pwm_vec[i]);
    end

endmodule

`default_nettype wire

// ==== hw/rgbw_frame_dispenser.sv ====
// rgbw frame dispenser
// waits for the sync byte, gathers seven bytes and publishes them as one frame
`timescale 1ns/1ns
`default_nettype none

module rgbw_frame_dispenser (
    input  logic                   clk,
    input  logic                   reset_sig,
    input  logic [7:0]             rx_byte,
    input  logic                   byte_rdy,
    output rgbw_pkg::rgbw_frame_t  frame,
    output logic                   frame_valid
);

    logic [7:0]            byte_q;
    logic                  rdy_q;
    logic                  rdy_prev;
    logic                  rdy_edge;
    logic [3:0]            byte_cnt;
    rgbw_pkg::rgbw_frame_t shadow;

    // new byte is present for exactly one cycle
    assign rdy_edge = rdy_q & ~rdy_prev;

    // incoming byte is held by the receiver, no reset needed
    always_ff @(posedge clk) begin
        byte_q <= rx_byte;
    end

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            rdy_q       <= 1'b0;
            rdy_prev    <= 1'b0;
            byte_cnt    <= 4'd0;
            frame       <= '0;
            frame_valid <= 1'b0;
        end else begin
            rdy_q       <= byte_rdy;
            rdy_prev    <= rdy_q;
            frame_valid <= 1'b0;

            if (rdy_edge) begin
                case (byte_cnt)
                    4'd0: begin
                        // stay here until the marker shows up
                        if (byte_q == rgbw_pkg::SYNC_BYTE) begin
                            byte_cnt <= 4'd1;
                        end
                    end
                    4'd1: begin
                        shadow.lint <= byte_q;
                        byte_cnt    <= 4'd2;
                    end
                    4'd2: begin
                        shadow.color_idx <= byte_q;
                        byte_cnt         <= 4'd3;
                    end
                    4'd3: begin
                        shadow.red <= byte_q;
                        byte_cnt   <= 4'd4;
                    end
                    4'd4: begin
                        shadow.green <= byte_q;
                        byte_cnt     <= 4'd5;
                    end
                    4'd5: begin
                        shadow.blue <= byte_q;
                        byte_cnt    <= 4'd6;
                    end
                    4'd6: begin
                        shadow.white <= byte_q;
                        byte_cnt     <= 4'd7;
                    end
                    4'd7: begin
                        // mode byte completes the frame, publish all fields at once
                        frame       <= {shadow.lint, shadow.color_idx, shadow.red,
                                        shadow.green, shadow.blue, shadow.white, byte_q};
                        frame_valid <= 1'b1;
                        byte_cnt    <= 4'd0;
                    end
                    default: byte_cnt <= 4'd0;
                endcase
            end
        end
    end

    a_byte_cnt_range: assert property (@(posedge clk) disable iff (!reset_sig)
        byte_cnt <= 4'd7);

    a_valid_single: assert property (@(posedge clk) disable iff (!reset_sig)
        frame_valid |=> !frame_valid);

endmodule

`default_nettype wire

// ==== hw/rgbw_led_top.sv ====
// rgbw led dimmer top
// spi receiver, frame dispenser, scaler, envelope and pwm mixer
`timescale 1ns/1ns
`default_nettype none

module rgbw_led_top #(
    parameter int ENV_PRESCALE = 1024
) (
    input  logic                  clk,
    input  logic                  reset_sig,
    input  logic                  sclk,
    input  logic                  mosi,
    input  logic                  cs_n,
    output logic                  pwm_r,
    output logic                  pwm_g,
    output logic                  pwm_b,
    output logic                  pwm_w,
    output rgbw_pkg::rgbw_frame_t status_frame,
    output logic                  status_valid
);

    logic [7:0]           rx_byte;
    logic                 byte_rdy;
    logic [7:0]           env;
    rgbw_pkg::rgbw_chan_t scaled;

    spi_byte_rx u_spi_rx (
        .clk       (clk),
        .reset_sig (reset_sig),
        .sclk      (sclk),
        .mosi      (mosi),
        .cs_n      (cs_n),
        .rx_byte   (rx_byte),
        .byte_rdy  (byte_rdy)
    );

    // decoded frame doubles as the status output
    rgbw_frame_dispenser u_dispenser (
        .clk         (clk),
        .reset_sig   (reset_sig),
        .rx_byte     (rx_byte),
        .byte_rdy    (byte_rdy),
        .frame       (status_frame),
        .frame_valid (status_valid)
    );

    intensity_scaler u_scaler (
        .clk       (clk),
        .reset_sig (reset_sig),
        .frame     (status_frame),
        .scaled    (scaled)
    );

    effect_envelope #(
        .ENV_PRESCALE (ENV_PRESCALE)
    ) u_envelope (
        .clk         (clk),
        .reset_sig   (reset_sig),
        .frame       (status_frame),
        .frame_valid (status_valid),
        .env         (env)
    );

    pwm_mixer u_mixer (
        .clk       (clk),
        .reset_sig (reset_sig),
        .scaled    (scaled),
        .env       (env),
        .pwm_r     (pwm_r),
        .pwm_g     (pwm_g),
        .pwm_b     (pwm_b),
        .pwm_w     (pwm_w)
    );

endmodule

`default_nettype wire

// ==== hw/rgbw_pkg.sv ====
// rgbw dimmer shared types
// frame and channel structs, sync marker and effect mode codes
`default_nettype none

package rgbw_pkg;

    // one decoded frame, in wire order after the sync byte
    typedef struct packed {
        logic [7:0] lint;
        logic [7:0] color_idx;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic [7:0] white;
        logic [7:0] mode;
    } rgbw_frame_t;

    // four colour values, used for scaled colours and pwm duties
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic [7:0] white;
    } rgbw_chan_t;

    // frame start marker
    localparam logic [7:0] SYNC_BYTE = 8'h55;

    // effect modes, anything above breathe runs as steady
    localparam logic [7:0] MODE_STEADY  = 8'd0;
    localparam logic [7:0] MODE_BLINK   = 8'd1;
    localparam logic [7:0] MODE_BREATHE = 8'd2;

endpackage

`default_nettype wire

// ==== hw/spi_byte_rx.sv ====
// spi mode-0 slave receiver
// synchronizes the spi pins and assembles msb-first bytes
`timescale 1ns/1ns
`default_nettype none

module spi_byte_rx (
    input  logic       clk,
    input  logic       reset_sig,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       cs_n,
    output logic [7:0] rx_byte,
    output logic       byte_rdy
);

    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] cs_sync;
    logic       sclk_prev;
    logic       cs_prev;
    logic       sclk_rise;
    logic       cs_rise;
    logic [6:0] shift_reg;
    logic [3:0] bit_cnt;

    // edges seen on the synchronized pins
    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign cs_rise   = cs_sync[1] & ~cs_prev;

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            cs_sync   <= 2'b11;
            sclk_prev <= 1'b0;
            cs_prev   <= 1'b1;
            bit_cnt   <= 4'd0;
            byte_rdy  <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            cs_sync   <= {cs_sync[0], cs_n};
            sclk_prev <= sclk_sync[1];
            cs_prev   <= cs_sync[1];
            byte_rdy  <= 1'b0;

            if (cs_rise) begin
                // deselect drops any partial byte
                bit_cnt <= 4'd0;
            end else if (sclk_rise && !cs_sync[1]) begin
                if (bit_cnt == 4'd7) begin
                    rx_byte  <= {shift_reg, mosi_sync[1]};
                    byte_rdy <= 1'b1;
                    bit_cnt  <= 4'd0;
                end else begin
                    shift_reg <= {shift_reg[5:0], mosi_sync[1]};
                    bit_cnt   <= bit_cnt + 4'd1;
                end
            end
        end
    end

    a_bit_cnt_range: assert property (@(posedge clk) disable iff (!reset_sig)
        bit_cnt <= 4'd7);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rgbw dimmer testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_rgbw_led \
    -f sim.f -Mdir obj_dir -o tb_rgbw_led
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rgbw_led > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim.f ====
hw/rgbw_pkg.sv
hw/spi_byte_rx.sv
hw/rgbw_frame_dispenser.sv
hw/intensity_scaler.sv
hw/effect_envelope.sv
hw/pwm_mixer.sv
hw/rgbw_led_top.sv
verification/tb_rgbw_led.sv

// ==== verification/tb_rgbw_led.sv ====
// rgbw dimmer testbench
// random spi frames checked against a reference model and measured pwm duties
`timescale 1ns/1ns
`default_nettype none

module tb_rgbw_led;

    logic                  clk = 1'b0;
    logic                  reset_sig;
    logic                  sclk;
    logic                  mosi;
    logic                  cs_n;
    logic                  pwm_r;
    logic                  pwm_g;
    logic                  pwm_b;
    logic                  pwm_w;
    rgbw_pkg::rgbw_frame_t status_frame;
    logic                  status_valid;

    int                    error_count = 0;
    int                    check_count = 0;
    int                    valid_seen = 0;
    rgbw_pkg::rgbw_frame_t captured;
    int                    hi_count[4];
    int                    steady[4];
    string                 chan_name[4];

    rgbw_led_top #(
        .ENV_PRESCALE (4)
    ) UUT (
        .clk          (clk),
        .reset_sig    (reset_sig),
        .sclk         (sclk),
        .mosi         (mosi),
        .cs_n         (cs_n),
        .pwm_r        (pwm_r),
        .pwm_g        (pwm_g),
        .pwm_b        (pwm_b),
        .pwm_w        (pwm_w),
        .status_frame (status_frame),
        .status_valid (status_valid)
    );

    always #50 clk = ~clk;

    // published frames, sampled away from the active edge
    always @(negedge clk) begin
        if (reset_sig && status_valid) begin
            valid_seen++;
            captured = status_frame;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Error: %s", msg);
    endtask

    // reference model, channel times (lint + 1) then times (env + 1), upper byte kept
    function automatic int scale_model(input logic [7:0] chan, input logic [7:0] lint);
        return (int'(chan) * (int'(lint) + 1)) >> 8;
    endfunction

    function automatic int duty_model(input int scaled_val, input int env_val);
        return (scaled_val * (env_val + 1)) >> 8;
    endfunction

    function automatic rgbw_pkg::rgbw_frame_t random_frame(input logic [7:0] mode);
        rgbw_pkg::rgbw_frame_t f;
        f.lint      = 8'($urandom);
        f.color_idx = 8'($urandom);
        f.red       = 8'($urandom);
        f.green     = 8'($urandom);
        f.blue      = 8'($urandom);
        f.white     = 8'($urandom);
        f.mode      = mode;
        if (mode == rgbw_pkg::MODE_BLINK || mode == rgbw_pkg::MODE_BREATHE) begin
            // keep red bright so the effect shows up on pwm_r
            f.lint = f.lint | 8'h80;
            f.red  = f.red | 8'h80;
        end
        return f;
    endfunction

    // one byte msb first, 8 clk per bit, data changes while sclk is low
    task automatic send_byte(input logic [7:0] value);
        for (int i = 7; i >= 0; i--) begin
            @(posedge clk);
            mosi <= value[i];
            sclk <= 1'b0;
            repeat (4) @(posedge clk);
            sclk <= 1'b1;
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic send_frame(input rgbw_pkg::rgbw_frame_t f, input int junk);
        logic [7:0] b;
        int         start;
        int         n;
        start = valid_seen;
        @(posedge clk);
        cs_n <= 1'b0;
        sclk <= 1'b0;
        repeat (4) @(posedge clk);
        for (n = 0; n < junk; n++) begin
            b = 8'($urandom);
            if (b == rgbw_pkg::SYNC_BYTE) begin
                b = 8'haa;
            end
            send_byte(b);
        end
        send_byte(rgbw_pkg::SYNC_BYTE);
        send_byte(f.lint);
        send_byte(f.color_idx);
        send_byte(f.red);
        send_byte(f.green);
        send_byte(f.blue);
        send_byte(f.white);
        send_byte(f.mode);
        @(posedge clk);
        sclk <= 1'b0;
        cs_n <= 1'b1;
        for (n = 0; n < 200 && valid_seen == start; n++) begin
            @(posedge clk);
        end
        // a stretched or repeated pulse would be counted within these cycles
        repeat (4) @(posedge clk);
        if (valid_seen == start) begin
            report_failure("status_valid did not pulse after a frame");
        end else if (valid_seen != start + 1) begin
            report_failure("status_valid pulsed more than once for one frame");
        end
    endtask

    task automatic check_frame(input rgbw_pkg::rgbw_frame_t f);
        check_value("status_frame.lint", f.lint, captured.lint);
        check_value("status_frame.color_idx", f.color_idx, captured.color_idx);
        check_value("status_frame.red", f.red, captured.red);
        check_value("status_frame.green", f.green, captured.green);
        check_value("status_frame.blue", f.blue, captured.blue);
        check_value("status_frame.white", f.white, captured.white);
        check_value("status_frame.mode", f.mode, captured.mode);
    endtask

    // high cycles per output over 256 samples, starting at the current negedge
    task automatic measure_window();
        for (int n = 0; n < 4; n++) begin
            hi_count[n] = 0;
        end
        for (int n = 0; n < 256; n++) begin
            hi_count[0] += int'(pwm_r);
            hi_count[1] += int'(pwm_g);
            hi_count[2] += int'(pwm_b);
            hi_count[3] += int'(pwm_w);
            @(negedge clk);
        end
    endtask

    // pwm_r rises only when the period counter wraps to 0
    task automatic wait_period_start();
        logic prev;
        bit   found;
        found = 1'b0;
        prev  = pwm_r;
        for (int n = 0; n < 3000 && !found; n++) begin
            @(negedge clk);
            if (pwm_r && !prev) begin
                found = 1'b1;
            end
            prev = pwm_r;
        end
        if (!found) begin
            report_failure("no pwm_r period start seen");
        end
    endtask

    initial begin
        int                    junk;
        int                    distinct[$];
        bit                    seen_on;
        bit                    seen_off;
        bit                    known;
        logic [7:0]            mode;
        rgbw_pkg::rgbw_frame_t f;

        reset_sig = 1'b0;
        sclk      = 1'b0;
        mosi      = 1'b0;
        cs_n      = 1'b1;
        chan_name = '{"pwm_r", "pwm_g", "pwm_b", "pwm_w"};
        void'($urandom(67545));

        repeat (2) @(posedge clk);
        reset_sig <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_value("pwm outputs after reset", 0, {pwm_r, pwm_g, pwm_b, pwm_w});
            check_value("status_valid after reset", 0, status_valid);
            check_value("status_frame after reset", 0, status_frame);
        end

        for (int i = 0; i < 10; i++) begin
            mode = (i < 4) ? 8'(i) : 8'($urandom % 4);
            f    = random_frame(mode);
            junk = (i % 2 == 1) ? 1 + int'($urandom % 3) : 0;
            send_frame(f, junk);
            check_frame(f);

            steady[0] = duty_model(scale_model(f.red, f.lint), 255);
            steady[1] = duty_model(scale_model(f.green, f.lint), 255);
            steady[2] = duty_model(scale_model(f.blue, f.lint), 255);
            steady[3] = duty_model(scale_model(f.white, f.lint), 255);

            if (mode == rgbw_pkg::MODE_BLINK) begin
                repeat (300) @(negedge clk);
                wait_period_start();
                seen_on  = 1'b0;
                seen_off = 1'b0;
                repeat (8) begin
                    measure_window();
                    // the envelope is shared, so every channel follows the red window
                    for (int c = 0; c < 4; c++) begin
                        check_value($sformatf("%s blink count", chan_name[c]),
                                    (hi_count[0] == 0) ? 0 : steady[c], hi_count[c]);
                    end
                    if (hi_count[0] == 0) begin
                        seen_off = 1'b1;
                    end else begin
                        seen_on = 1'b1;
                    end
                end
                check_value("pwm_r blink on window seen", 1, seen_on);
                check_value("pwm_r blink off window seen", 1, seen_off);
            end else if (mode == rgbw_pkg::MODE_BREATHE) begin
                repeat (300) @(negedge clk);
                wait_period_start();
                distinct.delete();
                repeat (8) begin
                    measure_window();
                    for (int c = 0; c < 4; c++) begin
                        check_value($sformatf("%s breathe count within steady", chan_name[c]),
                                    1, hi_count[c] <= steady[c]);
                    end
                    known = 1'b0;
                    foreach (distinct[k]) begin
                        if (distinct[k] == hi_count[0]) begin
                            known = 1'b1;
                        end
                    end
                    if (!known) begin
                        distinct.push_back(hi_count[0]);
                    end
                end
                check_value("pwm_r breathe distinct counts", 1, distinct.size() >= 3);
            end else begin
                // steady and unknown modes, any window after settling gives the duty
                repeat (512) @(negedge clk);
                measure_window();
                for (int c = 0; c < 4; c++) begin
                    check_value($sformatf("%s steady count", chan_name[c]),
                                steady[c], hi_count[c]);
                end
            end
        end

        $display("Finished with %0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
